// ==== rtl/vga_pkg.sv ====
`default_nettype none

// shared widths, mode defaults and payload types for the frame-buffer scan-out
package vga_pkg;

  // a small raster keeps simulation short
  // real modes are other values of the same module parameters
  localparam int H_VISIBLE_D = 8;
  localparam int H_FRONT_D   = 2;
  localparam int H_SYNC_D    = 2;
  localparam int H_BACK_D    = 2;
  localparam int H_WHOLE_D   = 14;

  localparam int V_VISIBLE_D = 4;
  localparam int V_FRONT_D   = 1;
  localparam int V_SYNC_D    = 1;
  localparam int V_BACK_D    = 1;
  localparam int V_WHOLE_D   = 7;

  // one frame-buffer word holds exactly one pixel, three channels of equal width
  localparam int PIXEL_BITS = 12;
  localparam int COLOR_BITS = 4;
  localparam int ADDR_BITS  = 16;

  // red sits in the top bits, then green, then blue
  typedef logic [PIXEL_BITS-1:0] pixel_t;

  // what the output side needs to know about one raster position
  typedef struct packed {
    logic visible;
    logic vsync;
    logic hsync;
  } pixel_ctx_t;

  // one posted host write waiting for the memory
  typedef struct packed {
    logic [ADDR_BITS-1:0] addr;
    pixel_t               pixel;
  } fb_write_t;

endpackage

`default_nettype wire

// ==== rtl/fb_mem_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// one request channel into the frame-buffer memory plus its read return
// a request moves on a cycle where req_valid and req_ready are both high
// read data comes back with rvalid exactly one cycle after the read moved
interface fb_mem_if;

  logic [vga_pkg::ADDR_BITS-1:0] addr;
  logic                          we;
  vga_pkg::pixel_t               wdata;
  logic                          req_valid;
  logic                          req_ready;

  // there is no rready, a requester that reads always takes the data
  vga_pkg::pixel_t               rdata;
  logic                          rvalid;

  // the requester holds addr, we and wdata steady until req_ready
  modport requester (
    output addr, we, wdata, req_valid,
    input  req_ready, rdata, rvalid
  );

  modport memory (
    input  addr, we, wdata, req_valid,
    output req_ready, rdata, rvalid
  );

endinterface

`default_nettype wire

// ==== rtl/vga_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

// raster position counters for one video mode
// the position only moves when step is high, so the consumer sets the pace
module vga_timing #(
  parameter int H_VISIBLE = 640,
  parameter int H_FRONT   = 16,
  parameter int H_SYNC    = 96,
  parameter int H_BACK    = 48,
  parameter int H_WHOLE   = 800,
  parameter int V_VISIBLE = 480,
  parameter int V_FRONT   = 10,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 33,
  parameter int V_WHOLE   = 525
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       step,
  output logic                       visible,
  output logic                       hsync,
  output logic                       vsync,
  output logic [$clog2(H_WHOLE)-1:0] column,
  output logic [$clog2(V_WHOLE)-1:0] row
);

  localparam int XB = $clog2(H_WHOLE);
  localparam int YB = $clog2(V_WHOLE);

  // the line and frame end where the back porch runs out
  localparam logic [XB-1:0] H_LAST   = XB'(H_VISIBLE + H_FRONT + H_SYNC + H_BACK - 1);
  localparam logic [YB-1:0] V_LAST   = YB'(V_VISIBLE + V_FRONT + V_SYNC + V_BACK - 1);
  localparam logic [XB-1:0] H_VIS    = XB'(H_VISIBLE);
  localparam logic [YB-1:0] V_VIS    = YB'(V_VISIBLE);

  // sync windows open right after the front porch
  localparam logic [XB-1:0] HS_BEGIN = XB'(H_VISIBLE + H_FRONT);
  localparam logic [XB-1:0] HS_END   = XB'(H_VISIBLE + H_FRONT + H_SYNC);
  localparam logic [YB-1:0] VS_BEGIN = YB'(V_VISIBLE + V_FRONT);
  localparam logic [YB-1:0] VS_END   = YB'(V_VISIBLE + V_FRONT + V_SYNC);

  always_ff @(posedge clk) begin
    if (reset) begin
      column <= '0;
      row    <= '0;
    end else if (step) begin
      if (column == H_LAST) begin
        column <= '0;
        row    <= (row == V_LAST) ? '0 : row + 1'b1;
      end else begin
        column <= column + 1'b1;
      end
    end
  end

  assign visible = (column < H_VIS) && (row < V_VIS);

  // both syncs are active low
  assign hsync = !((column >= HS_BEGIN) && (column < HS_END));
  assign vsync = !((row >= VS_BEGIN) && (row < VS_END));

  // the porches and sync must add up to no more than the whole line
  column_in_line: assert property (@(posedge clk) disable iff (reset)
    int'(column) < H_WHOLE && int'(row) < V_WHOLE)
    else $error("raster position left the whole line or frame");

endmodule

`default_nettype wire

// ==== rtl/context_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

// synchronous circular buffer with show-ahead output
// pop_data already holds the oldest entry whenever empty is low, and pop
// only moves on to the next one
module context_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  logic     pop,
  input  payload_t push_data,
  output payload_t pop_data,
  output logic     empty,
  output logic     full
);

  localparam int PB = $clog2(DEPTH);
  localparam int CB = PB + 1;

  localparam logic [PB-1:0] LAST_SLOT  = PB'(DEPTH - 1);
  localparam logic [CB-1:0] FULL_COUNT = CB'(DEPTH);

  payload_t          slots [DEPTH];
  logic     [PB-1:0] wr_ptr;
  logic     [PB-1:0] rd_ptr;
  logic     [CB-1:0] count;

  always_ff @(posedge clk) begin
    if (push) begin
      slots[wr_ptr] <= push_data;
    end
  end

  // pointers wrap by compare so any depth of two or more works
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign pop_data = slots[rd_ptr];
  assign empty    = (count == '0);
  assign full     = (count == FULL_COUNT);

  no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !full)
    else $error("push into a full fifo");

  no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
    else $error("pop from an empty fifo");

endmodule

`default_nettype wire

// ==== rtl/fb_pixel_stream.sv ====
`timescale 1ns/1ns
`default_nettype none

// scan-out engine
// walks the raster, reads every visible pixel from the frame buffer and
// gives one pixel with its syncs per valid pulse, in raster order
module fb_pixel_stream #(
  parameter int H_VISIBLE = 640,
  parameter int H_FRONT   = 16,
  parameter int H_SYNC    = 96,
  parameter int H_BACK    = 48,
  parameter int H_WHOLE   = 800,
  parameter int V_VISIBLE = 480,
  parameter int V_FRONT   = 10,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 33,
  parameter int V_WHOLE   = 525,
  parameter int CTX_DEPTH = 4
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           enable,
  output logic                           valid,
  output logic                           hsync,
  output logic                           vsync,
  output logic [vga_pkg::COLOR_BITS-1:0] red,
  output logic [vga_pkg::COLOR_BITS-1:0] grn,
  output logic [vga_pkg::COLOR_BITS-1:0] blu,
  fb_mem_if.requester                    mem
);

  localparam int AW = vga_pkg::ADDR_BITS;

  typedef enum logic {IDLE, READING} state_t;

  logic                       pos_visible;
  logic                       pos_hsync;
  logic                       pos_vsync;
  logic [$clog2(H_WHOLE)-1:0] column;
  logic [$clog2(V_WHOLE)-1:0] row;
  logic [AW-1:0]              addr_calc;
  logic [AW-1:0]              req_addr;

  state_t state;
  state_t next_state;
  logic   issue;
  logic   step;

  vga_pkg::pixel_ctx_t pos_ctx;
  vga_pkg::pixel_ctx_t ctx_head;
  logic                ctx_empty;
  logic                ctx_full;
  logic                ctx_pop;

  vga_pkg::pixel_t out_pixel;

  // the request register is the only thing that must be free before the
  // raster moves, so a held read stalls the raster and blanking runs freely
  assign issue = mem.req_valid && mem.req_ready;
  assign step  = enable && !ctx_full && (state == IDLE || issue);

  vga_timing #(
    .H_VISIBLE (H_VISIBLE),
    .H_FRONT   (H_FRONT),
    .H_SYNC    (H_SYNC),
    .H_BACK    (H_BACK),
    .H_WHOLE   (H_WHOLE),
    .V_VISIBLE (V_VISIBLE),
    .V_FRONT   (V_FRONT),
    .V_SYNC    (V_SYNC),
    .V_BACK    (V_BACK),
    .V_WHOLE   (V_WHOLE)
  ) raster (
    .clk     (clk),
    .reset   (reset),
    .step    (step),
    .visible (pos_visible),
    .hsync   (pos_hsync),
    .vsync   (pos_vsync),
    .column  (column),
    .row     (row)
  );

  // visible pixels are packed row by row with no gaps
  assign addr_calc = AW'(H_VISIBLE) * AW'(row) + AW'(column);

  // READING means the request register holds a read not yet taken
  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (step && pos_visible) next_state = READING;
      end
      READING: begin
        if (issue && !(step && pos_visible)) next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // pipeline point in front of the memory, loaded as the raster steps
  always_ff @(posedge clk) begin
    if (step && pos_visible) begin
      req_addr <= addr_calc;
    end
  end

  assign mem.req_valid = (state == READING);
  assign mem.addr      = req_addr;
  assign mem.we        = 1'b0;
  assign mem.wdata     = '0;

  // every position enters the fifo on the same edge it leaves the counters
  assign pos_ctx.visible = pos_visible;
  assign pos_ctx.vsync   = pos_vsync;
  assign pos_ctx.hsync   = pos_hsync;

  // blank positions leave at once, visible ones wait for their word
  assign ctx_pop = !ctx_empty && (!ctx_head.visible || mem.rvalid);

  context_fifo #(
    .payload_t (vga_pkg::pixel_ctx_t),
    .DEPTH     (CTX_DEPTH)
  ) ctx_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (step),
    .pop       (ctx_pop),
    .push_data (pos_ctx),
    .pop_data  (ctx_head),
    .empty     (ctx_empty),
    .full      (ctx_full)
  );

  // syncs idle high so a monitor ignores the line until the first pixel
  always_ff @(posedge clk) begin
    if (reset) begin
      valid     <= 1'b0;
      hsync     <= 1'b1;
      vsync     <= 1'b1;
      out_pixel <= '0;
    end else begin
      valid <= ctx_pop;
      if (ctx_pop) begin
        hsync     <= ctx_head.hsync;
        vsync     <= ctx_head.vsync;
        out_pixel <= ctx_head.visible ? mem.rdata : '0;
      end
    end
  end

  assign {red, grn, blu} = out_pixel;

  // returns come back in order, so a returning word always finds its own
  // visible context at the head of the fifo
  rdata_meets_context: assert property (@(posedge clk) disable iff (reset)
    mem.rvalid |-> !ctx_empty && ctx_head.visible)
    else $error("read data arrived without a visible context at the fifo head");

endmodule

`default_nettype wire

// ==== rtl/fb_write_port.sv ====
`timescale 1ns/1ns
`default_nettype none

// host pixel writer
// each wr_en strobe posts one pixel at (wr_x, wr_y) into a small queue, and
// the queue head is offered to the frame buffer as a write request
module fb_write_port #(
  parameter int H_VISIBLE   = 640,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                                                  clk,
  input  logic                                                  reset,
  input  logic                                                  wr_en,
  input  logic [$clog2(H_VISIBLE)-1:0]                          wr_x,
  input  logic [vga_pkg::ADDR_BITS-$clog2(H_VISIBLE)-1:0]       wr_y,
  input  vga_pkg::pixel_t                                       wr_pixel,
  output logic                                                  wr_full,
  fb_mem_if.requester                                           mem
);

  localparam int AW = vga_pkg::ADDR_BITS;

  vga_pkg::fb_write_t wr_entry;
  vga_pkg::fb_write_t queue_head;
  logic               queue_empty;

  // same row-major layout the scan-out reads back
  assign wr_entry.addr  = AW'(H_VISIBLE) * AW'(wr_y) + AW'(wr_x);
  assign wr_entry.pixel = wr_pixel;

  // the head leaves the queue on the cycle the arbiter takes it
  context_fifo #(
    .payload_t (vga_pkg::fb_write_t),
    .DEPTH     (QUEUE_DEPTH)
  ) queue (
    .clk       (clk),
    .reset     (reset),
    .push      (wr_en),
    .pop       (mem.req_valid && mem.req_ready),
    .push_data (wr_entry),
    .pop_data  (queue_head),
    .empty     (queue_empty),
    .full      (wr_full)
  );

  assign mem.req_valid = !queue_empty;
  assign mem.we        = 1'b1;
  assign mem.addr      = queue_head.addr;
  assign mem.wdata     = queue_head.pixel;

  strobe_not_full: assert property (@(posedge clk) disable iff (reset) wr_en |-> !wr_full)
    else $error("host write strobed while the queue is full");

endmodule

`default_nettype wire

// ==== rtl/fb_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

// fixed-priority arbiter onto the single-port frame buffer
// scan-out wins whenever it asks, the host gets the idle cycles
module fb_arbiter (
  input  logic        clk,
  input  logic        reset,
  fb_mem_if.memory    scan,
  fb_mem_if.memory    host,
  fb_mem_if.requester mem
);

  logic grant_scan;
  logic mem_read;
  logic owner_scan;

  // grant is purely combinational from the request lines
  assign grant_scan = scan.req_valid;

  assign mem.req_valid = scan.req_valid || host.req_valid;
  assign mem.addr      = grant_scan ? scan.addr  : host.addr;
  assign mem.we        = grant_scan ? scan.we    : host.we;
  assign mem.wdata     = grant_scan ? scan.wdata : host.wdata;

  assign scan.req_ready = mem.req_ready;
  assign host.req_ready = mem.req_ready && !grant_scan;

  // a read that moves now returns next cycle, so remember who issued it
  // writes leave the owner alone because they never return data
  assign mem_read = mem.req_valid && mem.req_ready && !mem.we;

  always_ff @(posedge clk) begin
    if (reset) begin
      owner_scan <= 1'b1;
    end else if (mem_read) begin
      owner_scan <= grant_scan;
    end
  end

  assign scan.rvalid = mem.rvalid && owner_scan;
  assign host.rvalid = mem.rvalid && !owner_scan;
  assign scan.rdata  = mem.rdata;
  assign host.rdata  = mem.rdata;

  scan_has_priority: assert property (@(posedge clk) disable iff (reset)
    (host.req_valid && host.req_ready) |-> !scan.req_valid)
    else $error("host granted while scan-out was requesting");

endmodule

`default_nettype wire

// ==== rtl/fb_sram.sv ====
`timescale 1ns/1ns
`default_nettype none

// single-port frame-buffer memory, one word per visible pixel
// it never stalls, writes land on the edge, reads return one cycle later
module fb_sram #(
  parameter int H_VISIBLE = 640,
  parameter int V_VISIBLE = 480
) (
  input  logic     clk,
  fb_mem_if.memory mem
);

  localparam int DEPTH = H_VISIBLE * V_VISIBLE;
  localparam int IB    = $clog2(DEPTH);

  vga_pkg::pixel_t          ram [DEPTH];
  vga_pkg::pixel_t          rdata_q;
  logic                     rvalid_q;
  logic            [IB-1:0] index;

  // the upper address bits stay zero for a legal request
  assign index = mem.addr[IB-1:0];

  always_ff @(posedge clk) begin
    if (mem.req_valid && mem.we) begin
      ram[index] <= mem.wdata;
    end
    if (mem.req_valid && !mem.we) begin
      rdata_q <= ram[index];
    end
  end

  // rvalid marks the cycle right after a read was taken
  always_ff @(posedge clk) begin
    rvalid_q <= mem.req_valid && !mem.we;
  end

  assign mem.req_ready = 1'b1;
  assign mem.rdata     = rdata_q;
  assign mem.rvalid    = rvalid_q;

  // both requesters compute addresses from raster coordinates
  addr_in_frame: assert property (@(posedge clk) mem.req_valid |-> int'(mem.addr) < DEPTH)
    else $error("frame-buffer address outside the visible area");

endmodule

`default_nettype wire

// ==== rtl/vga_fb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// frame-buffer scan-out subsystem
// scan-out and host writer share one SRAM through the priority arbiter
module vga_fb_top (
  input  logic                                                    clk,
  input  logic                                                    reset,
  input  logic                                                    enable,
  output logic                                                    valid,
  output logic                                                    hsync,
  output logic                                                    vsync,
  output logic [vga_pkg::COLOR_BITS-1:0]                          red,
  output logic [vga_pkg::COLOR_BITS-1:0]                          grn,
  output logic [vga_pkg::COLOR_BITS-1:0]                          blu,
  input  logic                                                    wr_en,
  input  logic [$clog2(vga_pkg::H_VISIBLE_D)-1:0]                 wr_x,
  input  logic [vga_pkg::ADDR_BITS-$clog2(vga_pkg::H_VISIBLE_D)-1:0] wr_y,
  input  logic [vga_pkg::PIXEL_BITS-1:0]                          wr_pixel,
  output logic                                                    wr_full
);

  fb_mem_if scan_bus ();
  fb_mem_if host_bus ();
  fb_mem_if mem_bus ();

  // four contexts cover the two-cycle lag from raster step to returned word
  fb_pixel_stream #(
    .H_VISIBLE (vga_pkg::H_VISIBLE_D),
    .H_FRONT   (vga_pkg::H_FRONT_D),
    .H_SYNC    (vga_pkg::H_SYNC_D),
    .H_BACK    (vga_pkg::H_BACK_D),
    .H_WHOLE   (vga_pkg::H_WHOLE_D),
    .V_VISIBLE (vga_pkg::V_VISIBLE_D),
    .V_FRONT   (vga_pkg::V_FRONT_D),
    .V_SYNC    (vga_pkg::V_SYNC_D),
    .V_BACK    (vga_pkg::V_BACK_D),
    .V_WHOLE   (vga_pkg::V_WHOLE_D),
    .CTX_DEPTH (4)
  ) stream (
    .clk    (clk),
    .reset  (reset),
    .enable (enable),
    .valid  (valid),
    .hsync  (hsync),
    .vsync  (vsync),
    .red    (red),
    .grn    (grn),
    .blu    (blu),
    .mem    (scan_bus.requester)
  );

  fb_write_port #(
    .H_VISIBLE   (vga_pkg::H_VISIBLE_D),
    .QUEUE_DEPTH (4)
  ) writer (
    .clk      (clk),
    .reset    (reset),
    .wr_en    (wr_en),
    .wr_x     (wr_x),
    .wr_y     (wr_y),
    .wr_pixel (wr_pixel),
    .wr_full  (wr_full),
    .mem      (host_bus.requester)
  );

  fb_arbiter arbiter (
    .clk   (clk),
    .reset (reset),
    .scan  (scan_bus.memory),
    .host  (host_bus.memory),
    .mem   (mem_bus.requester)
  );

  fb_sram #(
    .H_VISIBLE (vga_pkg::H_VISIBLE_D),
    .V_VISIBLE (vga_pkg::V_VISIBLE_D)
  ) sram (
    .clk (clk),
    .mem (mem_bus.memory)
  );

endmodule

`default_nettype wire

// ==== verification/vga_fb_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

// testbench for the frame-buffer scan-out subsystem
// a reference raster walks along with the valid pulses, and a private copy of
// the frame buffer gives the colours each visible position has to show
module vga_fb_tb;

  localparam int H_VIS    = vga_pkg::H_VISIBLE_D;
  localparam int H_SYNC_B = vga_pkg::H_VISIBLE_D + vga_pkg::H_FRONT_D;
  localparam int H_SYNC_E = H_SYNC_B + vga_pkg::H_SYNC_D;
  localparam int H_WHOLE  = vga_pkg::H_WHOLE_D;
  localparam int V_VIS    = vga_pkg::V_VISIBLE_D;
  localparam int V_SYNC_B = vga_pkg::V_VISIBLE_D + vga_pkg::V_FRONT_D;
  localparam int V_SYNC_E = V_SYNC_B + vga_pkg::V_SYNC_D;
  localparam int V_WHOLE  = vga_pkg::V_WHOLE_D;
  localparam int FB_WORDS = H_VIS * V_VIS;
  localparam int XW       = $clog2(H_VIS);
  localparam int YW       = vga_pkg::ADDR_BITS - XW;
  localparam int CW       = vga_pkg::COLOR_BITS;

  // the top level builds a four-entry host write queue
  localparam int QUEUE_DEPTH = 4;

  // host writes stop early enough that each one is seen two frames later
  localparam int FRAMES        = 7;
  localparam int LAST_WR_FRAME = FRAMES - 3;
  localparam int WAIT_LIMIT    = 200;
  localparam int FRAME_LIMIT   = 20000;

  logic                           clk;
  logic                           reset;
  logic                           enable;
  logic                           valid;
  logic                           hsync;
  logic                           vsync;
  logic [CW-1:0]                  red;
  logic [CW-1:0]                  grn;
  logic [CW-1:0]                  blu;
  logic                           wr_en;
  logic [XW-1:0]                  wr_x;
  logic [YW-1:0]                  wr_y;
  logic [vga_pkg::PIXEL_BITS-1:0] wr_pixel;
  logic                           wr_full;

  // a live write may show either its old or its new value until eff_frame
  vga_pkg::pixel_t old_val   [FB_WORDS];
  vga_pkg::pixel_t new_val   [FB_WORDS];
  int              eff_frame [FB_WORDS];

  int          ref_col;
  int          ref_row;
  int          ref_frame;
  int          queued;
  logic        seen_valid;
  logic [31:0] wr_rng;
  logic [31:0] en_rng;
  int          err_idle;
  int          err_sync;
  int          err_pixel;
  int          err_queue;
  int          err_timeout;

  vga_fb_top DUT (
    .clk      (clk),
    .reset    (reset),
    .enable   (enable),
    .valid    (valid),
    .hsync    (hsync),
    .vsync    (vsync),
    .red      (red),
    .grn      (grn),
    .blu      (blu),
    .wr_en    (wr_en),
    .wr_x     (wr_x),
    .wr_y     (wr_y),
    .wr_pixel (wr_pixel),
    .wr_full  (wr_full)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic close_run();
    $display("errors: idle %0d, sync %0d, pixel %0d, queue %0d, timeout %0d",
             err_idle, err_sync, err_pixel, err_queue, err_timeout);
    if (err_idle + err_sync + err_pixel + err_queue + err_timeout == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    err_timeout++;
  endtask

  // each call strobes once, and only when the queue has room
  task automatic host_write(input int a, input vga_pkg::pixel_t pix, input bit live);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (wr_full && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (wr_full) begin
      report_timeout("the host write queue never left the full state");
    end else begin
      @(posedge clk);
      wr_en    <= 1'b1;
      wr_x     <= XW'(a % H_VIS);
      wr_y     <= YW'(a / H_VIS);
      wr_pixel <= pix;
      // a write during frame N is certain to show from frame N+2 on
      old_val[a]   = live ? new_val[a] : pix;
      new_val[a]   = pix;
      eff_frame[a] = live ? ref_frame + 2 : 0;
      @(posedge clk);
      wr_en <= 1'b0;
    end
  endtask

  // random stretches with enable high, broken by short drops
  task automatic toggle_enable();
    int span;
    forever begin
      en_rng = xorshift32(en_rng);
      span = 5 + int'(en_rng % 40);
      @(posedge clk);
      enable <= 1'b1;
      repeat (span) @(posedge clk);
      en_rng = xorshift32(en_rng);
      span = 1 + int'(en_rng % 8);
      enable <= 1'b0;
      repeat (span) @(posedge clk);
    end
  endtask

  // host writes go on while the frame streams, with at most one pending
  // write per word
  task automatic host_traffic();
    int gap;
    int start;
    int a;
    int t;
    bit found;
    while (ref_frame <= LAST_WR_FRAME) begin
      wr_rng = xorshift32(wr_rng);
      gap = 1 + int'(wr_rng % 6);
      repeat (gap) @(posedge clk);
      wr_rng = xorshift32(wr_rng);
      start = int'(wr_rng % FB_WORDS);
      found = 1'b0;
      a = start;
      for (t = 0; t < FB_WORDS && !found; t++) begin
        a = (start + t) % FB_WORDS;
        found = (ref_frame >= eff_frame[a]);
      end
      if (found) begin
        wr_rng = xorshift32(wr_rng);
        host_write(a, wr_rng[vga_pkg::PIXEL_BITS-1:0], 1'b1);
      end
    end
  endtask

  // compare one valid pulse against the reference position, then move on
  task automatic check_pulse();
    logic            exp_hs;
    logic            exp_vs;
    logic            vis;
    logic            pix_ok;
    int              a;
    vga_pkg::pixel_t got;
    vga_pkg::pixel_t want;
    got    = {red, grn, blu};
    vis    = (ref_col < H_VIS) && (ref_row < V_VIS);
    exp_hs = !((ref_col >= H_SYNC_B) && (ref_col < H_SYNC_E));
    exp_vs = !((ref_row >= V_SYNC_B) && (ref_row < V_SYNC_E));
    assert (hsync === exp_hs && vsync === exp_vs)
    else begin
      err_sync++;
      $display("MISMATCH at %0t: frame %0d col %0d row %0d syncs h=%b v=%b, want h=%b v=%b",
               $time, ref_frame, ref_col, ref_row, hsync, vsync, exp_hs, exp_vs);
    end
    want   = '0;
    pix_ok = (got === '0);
    if (vis) begin
      a      = H_VIS * ref_row + ref_col;
      want   = new_val[a];
      pix_ok = (got === new_val[a]) || (ref_frame < eff_frame[a] && got === old_val[a]);
    end
    assert (pix_ok)
    else begin
      err_pixel++;
      $display("MISMATCH at %0t: frame %0d column %0d row %0d pixel %h, expected %h",
               $time, ref_frame, ref_col, ref_row, got, want);
    end
    seen_valid = 1'b1;
    if (ref_col == H_WHOLE - 1) begin
      ref_col = 0;
      if (ref_row == V_WHOLE - 1) begin
        ref_row = 0;
        ref_frame++;
      end else begin
        ref_row++;
      end
    end else begin
      ref_col++;
    end
  endtask

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (!reset && valid) begin
      check_pulse();
    end
  end

  // the write queue fills from host strobes and drains as the arbiter takes
  // each write, and wr_full has to follow that fill level
  always @(negedge clk) begin
    if (!reset) begin
      assert (wr_full === (queued == QUEUE_DEPTH))
      else begin
        err_queue++;
        $display("MISMATCH at %0t: wr_full %b with %0d writes queued",
                 $time, wr_full, queued);
      end
      queued = queued + int'(wr_en)
             - int'(DUT.host_bus.req_valid && DUT.host_bus.req_ready);
    end
  end

  // until the first pixel the output stays blank with both syncs inactive
  idle_before_first_pixel: assert property (@(posedge clk) disable iff (reset)
    (!seen_valid && !valid) |-> (hsync && vsync && {red, grn, blu} == '0))
    else begin
      err_idle++;
      $display("MISMATCH at %0t: outputs left their idle values before the first pixel",
               $time);
    end

  initial begin
    int cycles;
    int a;
    reset       = 1'b1;
    enable      = 1'b0;
    wr_en       = 1'b0;
    wr_x        = '0;
    wr_y        = '0;
    wr_pixel    = '0;
    ref_col     = 0;
    ref_row     = 0;
    ref_frame   = 0;
    queued      = 0;
    seen_valid  = 1'b0;
    wr_rng      = 32'd74687;
    en_rng      = ~32'd74687;
    err_idle    = 0;
    err_sync    = 0;
    err_pixel   = 0;
    err_queue   = 0;
    err_timeout = 0;
    for (a = 0; a < FB_WORDS; a++) begin
      eff_frame[a] = 0;
    end
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // fill the whole frame buffer while the scan-out is still off
    for (a = 0; a < FB_WORDS; a++) begin
      wr_rng = xorshift32(wr_rng);
      host_write(a, wr_rng[vga_pkg::PIXEL_BITS-1:0], 1'b0);
    end
    cycles = 0;
    @(negedge clk);
    while (DUT.host_bus.req_valid && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (DUT.host_bus.req_valid) begin
      report_timeout("the initial frame-buffer load never drained");
    end else begin
      fork
        toggle_enable();
        host_traffic();
      join_none
      cycles = 0;
      while (ref_frame < FRAMES && cycles < FRAME_LIMIT) begin
        @(negedge clk);
        cycles++;
      end
      if (ref_frame < FRAMES) begin
        report_timeout("the scan-out stopped delivering pixels");
      end
    end
    close_run();
  end

endmodule

`default_nettype wire

// ==== vga_fb_top.f ====
rtl/vga_pkg.sv
rtl/fb_mem_if.sv
rtl/vga_timing.sv
rtl/context_fifo.sv
rtl/fb_pixel_stream.sv
rtl/fb_write_port.sv
rtl/fb_arbiter.sv
rtl/fb_sram.sv
rtl/vga_fb_top.sv
verification/vga_fb_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module vga_fb_tb \
    -f vga_fb_top.f -Mdir obj_dir \
  && ./obj_dir/Vvga_fb_tb | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
